// ==== uart_sub.f ====
hdl/uart_line_pkg.sv
hdl/uart_host_pkg.sv
hdl/baud_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/sync_fifo.sv
hdl/uart_top.sv
verification/uart_asserts.sv
verification/uart_tb.sv

// ==== build.sh ====
#!/bin/sh
# compile and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module uart_tb -f uart_sub.f -o uart_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/uart_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
   exit 0
fi
exit 1

// ==== verification/uart_vectors.txt ====
# op data flag. R/F send a frame on rx with a good/bad stop bit, P pops and expects data and
# frame_err, E expects rx_empty = flag, T writes with flag = expected tx_full, D checks tx
R a5 0
R 3c 0
P a5 0
P 3c 0
F 5a 0
P 5a 1
# five frames without a pop, the fifth finds the FIFO full
R 01 0
R 80 0
R ff 0
R 00 0
R 77 0
P 01 0
P 80 0
P ff 0
P 00 0
E 00 1
T 55 0
T c3 0
D 00 0
# six writes back to back, the last two find the FIFO full
T 11 0
T 22 0
T 33 0
T 44 0
T 66 1
T 99 1
D 00 0

// ==== verification/uart_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tb
   import uart_host_pkg::*;
   ();

   localparam int dvsr     = 4;
   localparam int fifo_aw  = 2;
   // 16 ticks per bit, dvsr clocks per tick
   localparam int bit_clks = 16 * dvsr;

   logic  clk;
   logic  reset;
   logic  rx;
   logic  rd_uart;
   logic  wr_uart;
   byte_t w_data;
   byte_t r_data;
   logic  r_frame_err;
   logic  rx_empty;
   logic  tx_full;
   logic  tx;

   int checks      = 0;
   int errors      = 0;
   int cycles      = 0;
   int cycle_limit = 100000;

   logic [7:0] op_q[$];
   byte_t      data_q[$];
   logic       flag_q[$];
   byte_t      tx_expected[$];
   byte_t      tx_decoded[$];

   uart_top #(.dbit(8), .sb_tick(16), .dvsr(dvsr), .fifo_aw(fifo_aw)) dut_i
   (
      .clk         (clk),
      .reset       (reset),
      .rx          (rx),
      .rd_uart     (rd_uart),
      .r_data      (r_data),
      .r_frame_err (r_frame_err),
      .rx_empty    (rx_empty),
      .wr_uart     (wr_uart),
      .w_data      (w_data),
      .tx_full     (tx_full),
      .tx          (tx)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #50 clk = ~clk;
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("checks: %0d, errors: %0d", checks, errors);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("Error %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // inputs change 10 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   task automatic hold_rx(input logic level, input int n);
      rx = level;
      repeat (n) next_cycle();
   endtask

   task automatic send_frame(input byte_t b, input logic bad_stop);
      hold_rx(1'b0, bit_clks);
      for (int i = 0; i < 8; i++)
      begin
         hold_rx(b[i], bit_clks);
      end
      if (bad_stop)
      begin
         // low across the mid-stop sample, high again well before the next start
         hold_rx(1'b0, 40);
         hold_rx(1'b1, bit_clks - 40);
      end
      else
      begin
         hold_rx(1'b1, bit_clks);
      end
      // one idle bit between frames
      hold_rx(1'b1, bit_clks);
   endtask

   task automatic pop_and_check(input int k, input byte_t b, input logic fe);
      while (rx_empty)
      begin
         next_cycle();
      end
      check($sformatf("vector %0d rx data", k), b, r_data);
      check($sformatf("vector %0d frame_err", k), fe, r_frame_err);
      rd_uart = 1'b1;
      next_cycle();
      rd_uart = 1'b0;
   endtask

   task automatic pop_while_empty(input int k, input logic empty_exp);
      check($sformatf("vector %0d rx_empty", k), empty_exp, rx_empty);
      // a pop on an empty FIFO leaves it empty
      if (empty_exp)
      begin
         rd_uart = 1'b1;
         next_cycle();
         rd_uart = 1'b0;
         check($sformatf("vector %0d rx_empty after pop", k), 1, rx_empty);
      end
   endtask

   task automatic write_byte(input int k, input byte_t b, input logic full_exp);
      check($sformatf("vector %0d tx_full", k), full_exp, tx_full);
      wr_uart = 1'b1;
      w_data  = b;
      // bytes written while full never reach the line
      if (!full_exp)
      begin
         tx_expected.push_back(b);
      end
      next_cycle();
      wr_uart = 1'b0;
   endtask

   task automatic drain_and_compare(input int k);
      int n;
      while (tx_decoded.size() < tx_expected.size())
      begin
         next_cycle();
      end
      // long enough for one more frame to show up
      repeat (12 * bit_clks) next_cycle();
      check($sformatf("vector %0d tx byte count", k), tx_expected.size(), tx_decoded.size());
      n = (tx_decoded.size() < tx_expected.size()) ? tx_decoded.size() : tx_expected.size();
      for (int i = 0; i < n; i++)
      begin
         check($sformatf("vector %0d tx byte %0d", k, i), tx_expected[i], tx_decoded[i]);
      end
      tx_expected.delete();
      tx_decoded.delete();
   endtask

   task automatic read_vectors();
      int          fd;
      string       line;
      logic [7:0]  op;
      logic [31:0] d;
      logic [31:0] f;
      fd = $fopen("verification/uart_vectors.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("could not open verification/uart_vectors.txt");
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#")
            begin
               if ($sscanf(line, "%c %h %h", op, d, f) == 3)
               begin
                  op_q.push_back(op);
                  data_q.push_back(d[7:0]);
                  flag_q.push_back(f[0]);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // tx decoder, samples on the falling clock edge near mid-bit
   initial
   begin : tx_monitor
      byte_t b;
      @(negedge reset);
      forever
      begin
         @(negedge clk);
         if (tx === 1'b0)
         begin
            repeat (bit_clks / 2 - 1) @(negedge clk);
            if (tx !== 1'b0)
            begin
               errors++;
               $display("tx start bit did not stay low until mid-bit");
            end
            for (int i = 0; i < 8; i++)
            begin
               repeat (bit_clks) @(negedge clk);
               b[i] = tx;
            end
            repeat (bit_clks) @(negedge clk);
            if (tx !== 1'b1)
            begin
               errors++;
               $display("tx stop bit was low");
            end
            tx_decoded.push_back(b);
         end
      end
   end

   initial
   begin : main
      reset   = 1'b1;
      rx      = 1'b1;
      rd_uart = 1'b0;
      wr_uart = 1'b0;
      w_data  = '0;
      read_vectors();
      // 12 bit periods per vector plus margin
      cycle_limit = op_q.size() * 12 * bit_clks + 2000;
      repeat (3) @(posedge clk);
      #10;
      reset = 1'b0;
      check("reset tx", 1, tx);
      check("reset rx_empty", 1, rx_empty);
      check("reset tx_full", 0, tx_full);
      next_cycle();
      for (int k = 0; k < op_q.size(); k++)
      begin
         case (op_q[k])
            "R": send_frame(data_q[k], 1'b0);
            "F": send_frame(data_q[k], 1'b1);
            "P": pop_and_check(k, data_q[k], flag_q[k]);
            "E": pop_while_empty(k, flag_q[k]);
            "T": write_byte(k, data_q[k], flag_q[k]);
            "D": drain_and_compare(k);
            default:
            begin
               errors++;
               $display("vector %0d has an unknown opcode", k);
            end
         endcase
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("PASS: all tests");
      end
      else
      begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/uart_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_asserts
   #(
      parameter int dvsr = 163
   )
   (
      input wire clk,
      input wire reset,
      input wire tx,
      input wire s_tick,
      input wire rx_empty,
      input wire rd_uart,
      input wire rx_done_tick
   );

   // line idles high while in reset
   tx_high_in_reset: assert property (@(posedge clk) reset |-> tx)
      else $error("tx low while reset is asserted");

   // a pop on an empty receive FIFO with no incoming word leaves it empty
   empty_read_no_move: assert property (@(posedge clk) disable iff (reset)
      (rx_empty && rd_uart && !rx_done_tick) |=> rx_empty)
      else $error("read on empty receive FIFO changed its state");

   // one clock wide and back again every dvsr clocks
   tick_period: assert property (@(posedge clk) disable iff (reset)
      s_tick |=> !s_tick ##(dvsr - 1) s_tick)
      else $error("s_tick is not a one clock pulse every dvsr clocks");

endmodule

bind uart_top uart_asserts #(.dvsr(dvsr)) asserts_i
(
   .clk          (clk),
   .reset        (reset),
   .tx           (tx),
   .s_tick       (s_tick),
   .rx_empty     (rx_empty),
   .rd_uart      (rd_uart),
   .rx_done_tick (rx_done_tick)
);

`default_nettype wire

// ==== hdl/uart_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_top
   import uart_host_pkg::*;
   #(
      parameter int dbit    = 8,
      parameter int sb_tick = 16,
      parameter int dvsr    = 163,
      parameter int fifo_aw = 2
   )
   (
      input  wire        clk,
      input  wire        reset,
      input  wire        rx,
      input  wire        rd_uart,
      output byte_t      r_data,
      output logic       r_frame_err,
      output logic       rx_empty,
      input  wire        wr_uart,
      input  wire byte_t w_data,
      output logic       tx_full,
      output logic       tx
   );

   logic     s_tick;
   logic     rx_done_tick, rx_frame_err;
   byte_t    rx_dout;
   rx_word_t rx_word, rx_head;
   logic     tx_empty, tx_done_tick;
   byte_t    tx_head;

   baud_gen #(.dvsr(dvsr)) baud_gen_i
   (
      .clk    (clk),
      .reset  (reset),
      .s_tick (s_tick)
   );

   uart_rx #(.dbit(dbit), .sb_tick(sb_tick)) uart_rx_i
   (
      .clk          (clk),
      .reset        (reset),
      .rx           (rx),
      .s_tick       (s_tick),
      .rx_done_tick (rx_done_tick),
      .dout         (rx_dout),
      .frame_err    (rx_frame_err)
   );

   assign rx_word = '{data: rx_dout, frame_err: rx_frame_err};

   // a word arriving while full is dropped by the FIFO
   sync_fifo #(.payload_t(rx_word_t), .fifo_aw(fifo_aw)) rx_fifo
   (
      .clk    (clk),
      .reset  (reset),
      .wr     (rx_done_tick),
      .rd     (rd_uart),
      .w_data (rx_word),
      .r_data (rx_head),
      .empty  (rx_empty),
      .full   ()
   );

   assign r_data      = rx_head.data;
   assign r_frame_err = rx_head.frame_err;

   sync_fifo #(.payload_t(byte_t), .fifo_aw(fifo_aw)) tx_fifo
   (
      .clk    (clk),
      .reset  (reset),
      .wr     (wr_uart),
      .rd     (tx_done_tick),
      .w_data (w_data),
      .r_data (tx_head),
      .empty  (tx_empty),
      .full   (tx_full)
   );

   // transmitter runs whenever bytes are waiting
   uart_tx #(.dbit(dbit), .sb_tick(sb_tick)) uart_tx_i
   (
      .clk          (clk),
      .reset        (reset),
      .tx_start     (~tx_empty),
      .s_tick       (s_tick),
      .din          (tx_head),
      .tx_done_tick (tx_done_tick),
      .tx           (tx)
   );

endmodule

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module sync_fifo
   #(
      parameter type payload_t = logic [7:0],
      parameter int  fifo_aw   = 2
   )
   (
      input  wire           clk,
      input  wire           reset,
      input  wire           wr,
      input  wire           rd,
      input  wire payload_t w_data,
      output payload_t      r_data,
      output logic          empty,
      output logic          full
   );

   payload_t mem [2**fifo_aw];

   logic [fifo_aw-1:0] w_ptr, r_ptr;
   logic [fifo_aw-1:0] w_ptr_succ, r_ptr_succ;
   logic               full_reg, empty_reg;
   logic               wr_en, rd_en;

   // reads on an empty FIFO do nothing
   assign rd_en = rd & ~empty_reg;
   // a pop in the same cycle frees a slot for the write
   assign wr_en = wr & (~full_reg | rd_en);

   assign w_ptr_succ = w_ptr + 1'b1;
   assign r_ptr_succ = r_ptr + 1'b1;

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[w_ptr] <= w_data;
      end
   end

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         w_ptr     <= '0;
         r_ptr     <= '0;
         full_reg  <= 1'b0;
         empty_reg <= 1'b1;
      end
      else
      begin
         case ({wr_en, rd_en})
            2'b01:
            begin
               r_ptr     <= r_ptr_succ;
               full_reg  <= 1'b0;
               empty_reg <= (r_ptr_succ == w_ptr);
            end
            2'b10:
            begin
               w_ptr     <= w_ptr_succ;
               empty_reg <= 1'b0;
               full_reg  <= (w_ptr_succ == r_ptr);
            end
            2'b11:
            begin
               // count unchanged
               w_ptr <= w_ptr_succ;
               r_ptr <= r_ptr_succ;
            end
            default:
            begin
            end
         endcase
      end
   end

   // first word fall through
   assign r_data = mem[r_ptr];
   assign empty  = empty_reg;
   assign full   = full_reg;

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx
   import uart_line_pkg::*, uart_host_pkg::*;
   #(
      parameter int dbit    = 8,
      parameter int sb_tick = 16
   )
   (
      input  wire        clk,
      input  wire        reset,
      input  wire        tx_start,
      input  wire        s_tick,
      input  wire byte_t din,
      output logic       tx_done_tick,
      output logic       tx
   );

   localparam int s_max = (os_rate > sb_tick) ? os_rate : sb_tick;
   localparam int sw    = $clog2(s_max);
   localparam int nw    = (dbit > 1) ? $clog2(dbit) : 1;

   // same four phases as the receiver
   rx_state_t     state_reg, state_next;
   logic [sw-1:0] s_reg, s_next;
   logic [nw-1:0] n_reg, n_next;
   byte_t         b_reg, b_next;
   logic          tx_reg, tx_next;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         state_reg <= idle;
         s_reg     <= '0;
         n_reg     <= '0;
         tx_reg    <= 1'b1;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
         tx_reg    <= tx_next;
      end
   end

   always_ff @(posedge clk)
   begin
      b_reg <= b_next;
   end

   always_comb
   begin
      state_next   = state_reg;
      s_next       = s_reg;
      n_next       = n_reg;
      b_next       = b_reg;
      tx_next      = tx_reg;
      tx_done_tick = 1'b0;
      case (state_reg)
         idle:
         begin
            tx_next = 1'b1;
            if (tx_start)
            begin
               state_next = start;
               s_next     = '0;
               b_next     = din;
            end
         end
         start:
         begin
            tx_next = 1'b0;
            if (s_tick)
            begin
               if (s_reg == sw'(os_rate - 1))
               begin
                  state_next = data;
                  s_next     = '0;
                  n_next     = '0;
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
         data:
         begin
            tx_next = b_reg[0];
            if (s_tick)
            begin
               if (s_reg == sw'(os_rate - 1))
               begin
                  s_next = '0;
                  b_next = b_reg >> 1;
                  if (n_reg == nw'(dbit - 1))
                  begin
                     state_next = stop;
                  end
                  else
                  begin
                     n_next = n_reg + 1'b1;
                  end
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
         stop:
         begin
            tx_next = 1'b1;
            if (s_tick)
            begin
               if (s_reg == sw'(sb_tick - 1))
               begin
                  state_next   = idle;
                  tx_done_tick = 1'b1;
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
         default:
            state_next = idle;
      endcase
   end

   // registered so the line never glitches
   assign tx = tx_reg;

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx
   import uart_line_pkg::*, uart_host_pkg::*;
   #(
      parameter int dbit    = 8,
      parameter int sb_tick = 16
   )
   (
      input  wire   clk,
      input  wire   reset,
      input  wire   rx,
      input  wire   s_tick,
      output logic  rx_done_tick,
      output byte_t dout,
      output logic  frame_err
   );

   localparam int s_max = (os_rate > sb_tick) ? os_rate : sb_tick;
   localparam int sw    = $clog2(s_max);
   localparam int nw    = (dbit > 1) ? $clog2(dbit) : 1;

   rx_state_t     state_reg, state_next;
   logic [sw-1:0] s_reg, s_next;
   logic [nw-1:0] n_reg, n_next;
   byte_t         b_reg, b_next;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         state_reg <= idle;
         s_reg     <= '0;
         n_reg     <= '0;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
      end
   end

   // shift register for the incoming data bits
   always_ff @(posedge clk)
   begin
      b_reg <= b_next;
   end

   always_comb
   begin
      state_next   = state_reg;
      s_next       = s_reg;
      n_next       = n_reg;
      b_next       = b_reg;
      rx_done_tick = 1'b0;
      case (state_reg)
         idle:
            if (!rx)
            begin
               state_next = start;
               s_next     = '0;
            end
         start:
            if (s_tick)
            begin
               if (s_reg == sw'(mid_tick))
               begin
                  // line back high at mid start, treat as a glitch
                  if (rx)
                  begin
                     state_next = idle;
                  end
                  else
                  begin
                     state_next = data;
                     s_next     = '0;
                     n_next     = '0;
                  end
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         data:
            if (s_tick)
            begin
               if (s_reg == sw'(os_rate - 1))
               begin
                  s_next = '0;
                  // lsb arrives first
                  b_next = {rx, b_reg[7:1]};
                  if (n_reg == nw'(dbit - 1))
                  begin
                     state_next = stop;
                  end
                  else
                  begin
                     n_next = n_reg + 1'b1;
                  end
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         stop:
            if (s_tick)
            begin
               if (s_reg == sw'(sb_tick - 1))
               begin
                  state_next   = idle;
                  rx_done_tick = 1'b1;
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         default:
            state_next = idle;
      endcase
   end

   assign dout = b_reg;

   // stop bit sampled low at the last stop tick
   assign frame_err = rx_done_tick & ~rx;

endmodule

`default_nettype wire

// ==== hdl/baud_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module baud_gen
   #(
      parameter int dvsr = 163
   )
   (
      input  wire  clk,
      input  wire  reset,
      output logic s_tick
   );

   localparam int cw = (dvsr > 1) ? $clog2(dvsr) : 1;

   logic [cw-1:0] cnt_reg;
   logic          wrap;

   // last count of the period
   assign wrap = (cnt_reg == cw'(dvsr - 1));

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         cnt_reg <= '0;
      end
      else if (wrap)
      begin
         cnt_reg <= '0;
      end
      else
      begin
         cnt_reg <= cnt_reg + 1'b1;
      end
   end

   // one clock wide, once every dvsr clocks
   assign s_tick = wrap;

endmodule

`default_nettype wire

// ==== hdl/uart_host_pkg.sv ====
`default_nettype none

package uart_host_pkg;

   typedef logic [7:0] byte_t;

   // received byte with its framing flag
   typedef struct packed
   {
      byte_t data;
      logic  frame_err;
   } rx_word_t;

endpackage

`default_nettype wire

// ==== hdl/uart_line_pkg.sv ====
`default_nettype none

package uart_line_pkg;

   // oversampling ticks per bit period
   localparam int os_rate = 16;

   // tick at which the start bit is confirmed, middle of the bit
   localparam int mid_tick = 7;

   typedef enum logic [1:0]
   {
      idle  = 2'b00,
      start = 2'b01,
      data  = 2'b10,
      stop  = 2'b11
   } rx_state_t;

endpackage

`default_nettype wire
